//--- common/radio_ctrl_pkg.sv
// --------------------------------------------------
// shared widths, address map and types for the
// radio-clock control path; all logic is on radio_clk
// slot registers sit at SR_DB_BASE + 16*slot + offset
// --------------------------------------------------
`default_nettype none

package radio_ctrl_pkg;

   // --------------------------------------------------
   // sizes
   // --------------------------------------------------
   localparam int NUM_SLOTS      = 2;
   localparam int CHANS_PER_SLOT = 2;
   localparam int GPIO_WIDTH     = 32;
   localparam int FP_GPIO_WIDTH  = 12;
   localparam int ADDR_WIDTH     = 8;

   // --------------------------------------------------
   // default address map
   // --------------------------------------------------
   localparam logic [ADDR_WIDTH-1:0] SR_DB_BASE = 8'd160;
   localparam logic [ADDR_WIDTH-1:0] SR_FP_SRC  = 8'd192;
   localparam int SLOT_STRIDE   = 16;
   localparam int SLOT_OFF_BITS = $clog2(SLOT_STRIDE);  // offset bits within a slot

   // register targets, values 0..7 are the slot offsets
   typedef enum logic [3:0] {
      ATR_IDLE = 4'd0,
      ATR_RX   = 4'd1,
      ATR_TX   = 4'd2,
      ATR_FDX  = 4'd3,
      DB_DDR   = 4'd4,
      FP_OUT   = 4'd5,
      FP_DDR   = 4'd6,
      MISC_OUT = 4'd7,
      FP_SRC   = 4'd8   // not a slot register
   } reg_sel_e;

   // encoded as {run_tx, run_rx}
   typedef enum logic [1:0] {
      IDLE        = 2'd0,
      RX_ONLY     = 2'd1,
      TX_ONLY     = 2'd2,
      FULL_DUPLEX = 2'd3
   } atr_state_e;

   // one decoded settings write
   typedef struct packed {
      logic                  valid;
      logic                  slot;
      reg_sel_e              target;
      logic [GPIO_WIDTH-1:0] data;
   } set_wr_t;

   typedef struct packed {
      logic [GPIO_WIDTH-1:0] atr_idle;
      logic [GPIO_WIDTH-1:0] atr_rx;
      logic [GPIO_WIDTH-1:0] atr_tx;
      logic [GPIO_WIDTH-1:0] atr_fdx;
      logic [GPIO_WIDTH-1:0] db_ddr;
      logic [GPIO_WIDTH-1:0] fp_out;
      logic [GPIO_WIDTH-1:0] fp_ddr;
      logic [GPIO_WIDTH-1:0] misc_out;
   } slot_regs_t;

   typedef struct packed {
      logic [GPIO_WIDTH-1:0] out;
      logic [GPIO_WIDTH-1:0] ddr;
   } gpio_drive_t;

endpackage

`default_nettype wire

//--- hw/settings_rx.sv
// --------------------------------------------------
// four-phase req/ack settings port
// host keeps addr/data stable while req is high and
// must not raise req again before ack has fallen
// unmapped addresses are acked but write nothing
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module settings_rx
   import radio_ctrl_pkg::*;
#(
   parameter logic [ADDR_WIDTH-1:0] SR_DB_BASE = radio_ctrl_pkg::SR_DB_BASE,
   parameter logic [ADDR_WIDTH-1:0] SR_FP_SRC  = radio_ctrl_pkg::SR_FP_SRC
)(
   input  wire logic                  radio_clk,
   input  wire logic                  i_rst_n,
   input  wire logic                  i_set_req,
   input  wire logic [ADDR_WIDTH-1:0] i_set_addr,
   input  wire logic [GPIO_WIDTH-1:0] i_set_data,
   output logic                       o_set_ack,
   output set_wr_t                    o_wr
);

   typedef enum logic [1:0] {
      WAIT_REQ,
      WRITE,
      ACK_HIGH
   } hs_state_e;

   hs_state_e             state;
   logic [ADDR_WIDTH-1:0] addr_off;
   logic                  in_slot_range;
   set_wr_t               dec_wr;

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------
   assign addr_off      = i_set_addr - SR_DB_BASE;
   assign in_slot_range = (i_set_addr >= SR_DB_BASE) &&
                          (addr_off < ADDR_WIDTH'(NUM_SLOTS * SLOT_STRIDE));

   always_comb begin
      dec_wr      = '0;
      dec_wr.data = i_set_data;
      if (in_slot_range) begin
         dec_wr.slot   = addr_off[SLOT_OFF_BITS];
         dec_wr.target = reg_sel_e'(addr_off[SLOT_OFF_BITS-1:0]);
         dec_wr.valid  = (addr_off[SLOT_OFF_BITS-1:0] <= 4'(MISC_OUT));  // 8..15 unused
      end else if (i_set_addr == SR_FP_SRC) begin
         dec_wr.target = FP_SRC;
         dec_wr.valid  = 1'b1;
      end
   end

   // --------------------------------------------------
   // handshake FSM
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         state     <= WAIT_REQ;
         o_set_ack <= 1'b0;
         o_wr      <= '0;
      end else begin
         o_wr.valid <= 1'b0;  // single-cycle strobe
         case (state)
            WAIT_REQ: begin
               if (i_set_req) begin
                  o_wr  <= dec_wr;  // decoded once per request
                  state <= WRITE;
               end
            end
            WRITE: begin
               state <= ACK_HIGH;  // registers take the write on this edge
            end
            ACK_HIGH: begin
               if (!o_set_ack) begin
                  o_set_ack <= 1'b1;
               end else if (!i_set_req) begin
                  o_set_ack <= 1'b0;
                  state     <= WAIT_REQ;
               end
            end
            default: state <= WAIT_REQ;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- db_control/db_regs.sv
// --------------------------------------------------
// settings register bank of one daughterboard slot
// takes only writes whose slot matches SLOT_INDEX
// FP_SRC writes belong to the front-panel mux
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module db_regs
   import radio_ctrl_pkg::*;
#(
   parameter int SLOT_INDEX = 0
)(
   input  wire logic                  radio_clk,
   input  wire logic                  i_rst_n,
   input  wire set_wr_t               i_wr,
   output slot_regs_t                 o_regs,
   output logic      [GPIO_WIDTH-1:0] o_misc_out
);

   logic hit;

   assign hit = i_wr.valid && (i_wr.slot == 1'(SLOT_INDEX)) && (i_wr.target != FP_SRC);

   // --------------------------------------------------
   // register file
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_regs <= '0;
      end else if (hit) begin
         case (i_wr.target)
            ATR_IDLE: o_regs.atr_idle <= i_wr.data;
            ATR_RX:   o_regs.atr_rx   <= i_wr.data;
            ATR_TX:   o_regs.atr_tx   <= i_wr.data;
            ATR_FDX:  o_regs.atr_fdx  <= i_wr.data;
            DB_DDR:   o_regs.db_ddr   <= i_wr.data;
            FP_OUT:   o_regs.fp_out   <= i_wr.data;
            FP_DDR:   o_regs.fp_ddr   <= i_wr.data;
            MISC_OUT: o_regs.misc_out <= i_wr.data;
            default: ;  // no slot register here
         endcase
      end
   end

   // misc out goes straight to the board, already registered
   assign o_misc_out = o_regs.misc_out;

endmodule

`default_nettype wire

//--- db_control/atr_select.sv
// --------------------------------------------------
// ATR GPIO drive for one slot
// run_rx/run_tx are the OR over the slot's channels
// drive and LEDs follow inputs by one cycle
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module atr_select
   import radio_ctrl_pkg::*;
(
   input  wire logic        radio_clk,
   input  wire logic        i_rst_n,
   input  wire logic        i_run_rx,
   input  wire logic        i_run_tx,
   input  wire slot_regs_t  i_regs,
   output gpio_drive_t      o_db_gpio,
   output logic      [2:0]  o_led
);

   atr_state_e            atr_state;
   logic [GPIO_WIDTH-1:0] atr_word;
   logic [2:0]            led_next;

   assign atr_state = atr_state_e'({i_run_tx, i_run_rx});

   // pick the ATR word for the current state
   always_comb begin
      case (atr_state)
         IDLE:        atr_word = i_regs.atr_idle;
         RX_ONLY:     atr_word = i_regs.atr_rx;
         TX_ONLY:     atr_word = i_regs.atr_tx;
         FULL_DUPLEX: atr_word = i_regs.atr_fdx;
         default:     atr_word = i_regs.atr_idle;
      endcase
   end

   // {rx, txrx_tx, txrx_rx}
   assign led_next = {i_run_rx & ~i_run_tx, i_run_tx, i_run_rx & i_run_tx};

   // --------------------------------------------------
   // output registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_db_gpio <= '0;
         o_led     <= '0;
      end else begin
         o_db_gpio.out <= atr_word;
         o_db_gpio.ddr <= i_regs.db_ddr;  // direction does not follow ATR
         o_led         <= led_next;
      end
   end

endmodule

`default_nettype wire

//--- hw/fp_gpio_mux.sv
// --------------------------------------------------
// front-panel GPIO source mux
// 2 source bits per pin, 0 = slot 0, else slot 1
// only the low FP_GPIO_WIDTH bits of the drive are used
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_gpio_mux
   import radio_ctrl_pkg::*;
(
   input  wire logic        radio_clk,
   input  wire logic        i_rst_n,
   input  wire set_wr_t     i_wr,
   input  wire slot_regs_t  i_slot_regs [NUM_SLOTS],
   output gpio_drive_t      o_fp_gpio
);

   localparam int SRC_WIDTH = 2 * FP_GPIO_WIDTH;

   logic [SRC_WIDTH-1:0] fp_src;
   gpio_drive_t          fp_next;
   logic                 pin_slot;

   // source register
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         fp_src <= '0;
      end else if (i_wr.valid && (i_wr.target == FP_SRC)) begin
         fp_src <= i_wr.data[SRC_WIDTH-1:0];
      end
   end

   // --------------------------------------------------
   // per-pin slot select
   // --------------------------------------------------
   always_comb begin
      fp_next  = '0;  // unused upper pins stay low
      pin_slot = 1'b0;
      for (int i = 0; i < FP_GPIO_WIDTH; i++) begin
         pin_slot       = (fp_src[2*i +: 2] != 2'd0);
         fp_next.out[i] = i_slot_regs[pin_slot].fp_out[i];
         fp_next.ddr[i] = i_slot_regs[pin_slot].fp_ddr[i];
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_fp_gpio <= '0;
      end else begin
         o_fp_gpio <= fp_next;
      end
   end

endmodule

`default_nettype wire

//--- hw/radio_ctrl_core.sv
// --------------------------------------------------
// radio-clock control path, two daughterboard slots
// slot s owns channels 2s and 2s+1
// single clock domain, no readback path
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_core
   import radio_ctrl_pkg::*;
#(
   parameter logic [ADDR_WIDTH-1:0] SR_DB_BASE = radio_ctrl_pkg::SR_DB_BASE,
   parameter logic [ADDR_WIDTH-1:0] SR_FP_SRC  = radio_ctrl_pkg::SR_FP_SRC
)(
   input  wire logic                                radio_clk,
   input  wire logic                                i_rst_n,
   // settings port
   input  wire logic                                i_set_req,
   input  wire logic [ADDR_WIDTH-1:0]               i_set_addr,
   input  wire logic [GPIO_WIDTH-1:0]               i_set_data,
   output logic                                     o_set_ack,
   // channel activity
   input  wire logic [NUM_SLOTS*CHANS_PER_SLOT-1:0] i_rx_running,
   input  wire logic [NUM_SLOTS*CHANS_PER_SLOT-1:0] i_tx_running,
   // board side
   output gpio_drive_t                              o_db0_gpio,
   output gpio_drive_t                              o_db1_gpio,
   output gpio_drive_t                              o_fp_gpio,
   output logic      [2:0]                          o_radio_led0,
   output logic      [2:0]                          o_radio_led1,
   output logic      [GPIO_WIDTH-1:0]               o_misc_out0,
   output logic      [GPIO_WIDTH-1:0]               o_misc_out1
);

   set_wr_t               set_wr;
   slot_regs_t            slot_regs [NUM_SLOTS];
   gpio_drive_t           db_gpio   [NUM_SLOTS];
   logic [2:0]            led       [NUM_SLOTS];
   logic [GPIO_WIDTH-1:0] misc_out  [NUM_SLOTS];

   settings_rx #(
      .SR_DB_BASE (SR_DB_BASE),
      .SR_FP_SRC  (SR_FP_SRC)
   ) u_settings_rx (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_set_req  (i_set_req),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_set_ack  (o_set_ack),
      .o_wr       (set_wr)
   );

   // --------------------------------------------------
   // per-slot control
   // --------------------------------------------------
   for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
      db_regs #(
         .SLOT_INDEX (s)
      ) u_db_regs (
         .radio_clk  (radio_clk),
         .i_rst_n    (i_rst_n),
         .i_wr       (set_wr),
         .o_regs     (slot_regs[s]),
         .o_misc_out (misc_out[s])
      );

      atr_select u_atr_select (
         .radio_clk (radio_clk),
         .i_rst_n   (i_rst_n),
         .i_run_rx  (|i_rx_running[s*CHANS_PER_SLOT +: CHANS_PER_SLOT]),  // either channel
         .i_run_tx  (|i_tx_running[s*CHANS_PER_SLOT +: CHANS_PER_SLOT]),
         .i_regs    (slot_regs[s]),
         .o_db_gpio (db_gpio[s]),
         .o_led     (led[s])
      );
   end

   fp_gpio_mux u_fp_gpio_mux (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_wr        (set_wr),
      .i_slot_regs (slot_regs),
      .o_fp_gpio   (o_fp_gpio)
   );

   assign o_db0_gpio   = db_gpio[0];
   assign o_db1_gpio   = db_gpio[1];
   assign o_radio_led0 = led[0];
   assign o_radio_led1 = led[1];
   assign o_misc_out0  = misc_out[0];
   assign o_misc_out1  = misc_out[1];

endmodule

`default_nettype wire

//--- sim/radio_ctrl_core_sva.sv
// --------------------------------------------------
// settings handshake and reset properties
// bound into every radio_ctrl_core instance
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_core_sva
   import radio_ctrl_pkg::*;
(
   input wire logic                  radio_clk,
   input wire logic                  i_rst_n,
   input wire logic                  i_set_req,
   input wire logic                  i_set_ack,
   input wire gpio_drive_t           i_db0_gpio,
   input wire gpio_drive_t           i_db1_gpio,
   input wire gpio_drive_t           i_fp_gpio,
   input wire logic [2:0]            i_led0,
   input wire logic [2:0]            i_led1,
   input wire logic [GPIO_WIDTH-1:0] i_misc0,
   input wire logic [GPIO_WIDTH-1:0] i_misc1
);

   logic outputs_zero;

   assign outputs_zero = !i_set_ack && (i_db0_gpio == '0) && (i_db1_gpio == '0) &&
                         (i_fp_gpio == '0) && (i_led0 == '0) && (i_led1 == '0) &&
                         (i_misc0 == '0) && (i_misc1 == '0);

   ack_rise_needs_req: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $rose(i_set_ack) |-> $past(i_set_req))
      else $error("settings ack rose while req was low");

   ack_fall_needs_req_low: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $fell(i_set_ack) |-> !$past(i_set_req))
      else $error("settings ack fell while req was still high");

   // sync reset clears everything on the next edge
   outputs_clear_after_reset: assert property (@(posedge radio_clk)
      !i_rst_n |=> outputs_zero)
      else $error("outputs not zero in the cycle after reset");

endmodule

bind radio_ctrl_core radio_ctrl_core_sva u_core_sva (
   .radio_clk  (radio_clk),
   .i_rst_n    (i_rst_n),
   .i_set_req  (i_set_req),
   .i_set_ack  (o_set_ack),
   .i_db0_gpio (o_db0_gpio),
   .i_db1_gpio (o_db1_gpio),
   .i_fp_gpio  (o_fp_gpio),
   .i_led0     (o_radio_led0),
   .i_led1     (o_radio_led1),
   .i_misc0    (o_misc_out0),
   .i_misc1    (o_misc_out1)
);

`default_nettype wire

//--- sim/radio_ctrl_core_tb.sv
// --------------------------------------------------
// testbench for the radio-clock control path
// commands come from sim/radio_ctrl_stimulus.txt, so
// run it from the project root
// inputs change and outputs are read 1 ns after the edge
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_core_tb
   import radio_ctrl_pkg::*;
();

   localparam int    RESET_CYCLES    = 16;
   localparam int    CYCLES_PER_LINE = 40;
   localparam int    RUN_WIDTH       = NUM_SLOTS * CHANS_PER_SLOT;
   localparam string STIM_FILE       = "sim/radio_ctrl_stimulus.txt";

   logic                  radio_clk;
   logic                  rst_n;
   logic                  set_req;
   logic [ADDR_WIDTH-1:0] set_addr;
   logic [GPIO_WIDTH-1:0] set_data;
   logic [RUN_WIDTH-1:0]  rx_running;
   logic [RUN_WIDTH-1:0]  tx_running;
   logic                  set_ack;
   gpio_drive_t           db0_gpio;
   gpio_drive_t           db1_gpio;
   gpio_drive_t           fp_gpio;
   logic [2:0]            led0;
   logic [2:0]            led1;
   logic [GPIO_WIDTH-1:0] misc0;
   logic [GPIO_WIDTH-1:0] misc1;

   int    value_errors = 0;
   int    other_errors = 0;
   int    checks       = 0;
   int    cycles       = 0;
   int    cycle_limit  = 0;
   string stim_q[$];

   radio_ctrl_core DUT (
      .radio_clk    (radio_clk),
      .i_rst_n      (rst_n),
      .i_set_req    (set_req),
      .i_set_addr   (set_addr),
      .i_set_data   (set_data),
      .o_set_ack    (set_ack),
      .i_rx_running (rx_running),
      .i_tx_running (tx_running),
      .o_db0_gpio   (db0_gpio),
      .o_db1_gpio   (db1_gpio),
      .o_fp_gpio    (fp_gpio),
      .o_radio_led0 (led0),
      .o_radio_led1 (led1),
      .o_misc_out0  (misc0),
      .o_misc_out1  (misc1)
   );

   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;  // 40 ns period
   end

   // watchdog limit comes from the stimulus length
   always @(posedge radio_clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge radio_clk);
      #1;
   endtask

   // one register write over the four-phase handshake
   task automatic settings_write(input logic [ADDR_WIDTH-1:0] addr,
                                 input logic [GPIO_WIDTH-1:0] data);
      if (set_ack) begin
         other_errors++;
         $display("ack was still high when a new request started at %0t", $time);
      end
      set_addr = addr;
      set_data = data;
      set_req  = 1'b1;
      do begin
         @(posedge radio_clk);
         #1;
      end while (!set_ack);
      set_req = 1'b0;  // ack must drop after this
      do begin
         @(posedge radio_clk);
         #1;
      end while (set_ack);
      wait_cycles(4);
   endtask

   task automatic set_running(input logic [RUN_WIDTH-1:0] rx, input logic [RUN_WIDTH-1:0] tx);
      rx_running = rx;
      tx_running = tx;
      wait_cycles(4);
   endtask

   function automatic logic [GPIO_WIDTH-1:0] output_value(input string name, output bit known);
      known = 1'b1;
      case (name)
         "ack":     output_value = GPIO_WIDTH'(set_ack);
         "db0_out": output_value = db0_gpio.out;
         "db0_ddr": output_value = db0_gpio.ddr;
         "db1_out": output_value = db1_gpio.out;
         "db1_ddr": output_value = db1_gpio.ddr;
         "fp_out":  output_value = fp_gpio.out;
         "fp_ddr":  output_value = fp_gpio.ddr;
         "led0":    output_value = GPIO_WIDTH'(led0);
         "led1":    output_value = GPIO_WIDTH'(led1);
         "misc0":   output_value = misc0;
         "misc1":   output_value = misc1;
         default: begin
            known        = 1'b0;
            output_value = '0;
         end
      endcase
   endfunction

   task automatic check_output(input string name, input logic [GPIO_WIDTH-1:0] expected);
      logic [GPIO_WIDTH-1:0] got;
      bit                    known;
      got = output_value(name, known);
      checks++;
      if (!known) begin
         other_errors++;
         $display("stimulus names an output that does not exist: %s", name);
      end else if (got !== expected) begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic run_line(input string line);
      string                 cmd;
      string                 name;
      logic [GPIO_WIDTH-1:0] a;
      logic [GPIO_WIDTH-1:0] b;
      int                    n;
      n = $sscanf(line, "%s", cmd);
      if (n < 1 || cmd.getc(0) == "#")
         return;  // blank or comment
      case (cmd)
         "W": begin
            n = $sscanf(line, "%s %h %h", cmd, a, b);
            if (n == 3)
               settings_write(a[ADDR_WIDTH-1:0], b);
         end
         "R": begin
            n = $sscanf(line, "%s %h %h", cmd, a, b);
            if (n == 3)
               set_running(a[RUN_WIDTH-1:0], b[RUN_WIDTH-1:0]);
         end
         "C": begin
            n = $sscanf(line, "%s %s %h", cmd, name, a);
            if (n == 3)
               check_output(name, a);
         end
         default: n = 0;
      endcase
      if (n != 3) begin
         other_errors++;
         $display("stimulus line could not be used: %s", line);
      end
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin : main
      int    fd;
      string line;
      rst_n      = 1'b0;
      set_req    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      rx_running = '0;
      tx_running = '0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         other_errors++;
         $display("cannot open stimulus file %s", STIM_FILE);
      end else begin
         while ($fgets(line, fd) != 0)
            stim_q.push_back(line);
         $fclose(fd);
      end
      cycle_limit = CYCLES_PER_LINE * stim_q.size() + RESET_CYCLES + 4;

      repeat (RESET_CYCLES) @(posedge radio_clk);
      #1;
      rst_n = 1'b1;
      wait_cycles(4);
      foreach (stim_q[i])
         run_line(stim_q[i]);

      $display("checks run: %0d, value errors: %0d, other errors: %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/radio_ctrl_stimulus.txt
# W <addr hex> <data hex> : settings write | R <rx hex> <tx hex> : run bits, ch0 in bit 0
# C <output> <hex> : check ack, db0_out/ddr, db1_out/ddr, fp_out/ddr, led0/1, misc0/1
C ack 0
C db0_out 0
C db0_ddr 0
C db1_out 0
C db1_ddr 0
C fp_out 0
C fp_ddr 0
C led0 0
C led1 0
C misc0 0
C misc1 0
# ATR words and db ddr, slot 0 at a0, slot 1 at b0
W a0 11110000
W a1 22220001
W a2 33330002
W a3 44440003
W a4 0000ffff
W b0 55550010
W b1 66660011
W b2 77770012
W b3 88880013
W b4 ffff0000
C db0_out 11110000
C db0_ddr 0000ffff
C db1_out 55550010
C db1_ddr ffff0000
# run patterns, LEDs are {rx only, tx, full duplex}
R 1 0
C db0_out 22220001
C led0 4
C db1_out 55550010
C led1 0
R 2 8
C db0_out 22220001
C db1_out 77770012
C led1 2
R 3 3
C db0_out 44440003
C led0 3
C db1_out 55550010
C led1 0
R 4 c
C db0_out 11110000
C led0 0
C db1_out 88880013
C led1 3
R 0 2
C db0_out 33330002
C led0 2
C db1_out 55550010
# front panel, source word picks slot 1 for pins 1-3, 5-7, 10, 11
W a5 ffff0aaa
W a6 00000f0f
W b5 00000555
W b6 000000ff
C fp_out 00000aaa
C fp_ddr 00000f0f
W c0 ff70e4e4
C fp_out 00000644
C fp_ddr 000003ef
# misc out, then offset 9 and address 100 change nothing
W a7 cafe0001
W b7 0badf00d
C misc0 cafe0001
C misc1 0badf00d
W a9 12345678
W 64 87654321
C misc0 cafe0001
C misc1 0badf00d
C db0_out 33330002
C fp_out 00000644
C ack 0

//--- src.f
common/radio_ctrl_pkg.sv
hw/settings_rx.sv
db_control/db_regs.sv
db_control/atr_select.sv
hw/fp_gpio_mux.sv
hw/radio_ctrl_core.sv
sim/radio_ctrl_core_sva.sv
sim/radio_ctrl_core_tb.sv

//--- Makefile
# Verilator build and run for the radio control path testbench

VERILATOR ?= verilator
TOP       ?= radio_ctrl_core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
